// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f src.f --top-module tbRenameStage
	@out=$$(./obj_dir/VtbRenameStage); echo "$$out"; echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf obj_dir

// ==== source/instructionValues.sv ====
/*
  Source operand resolution
  Picks the register value, a finished ROB value or a same-cycle CDB result,
  otherwise reports the operand as waiting on its producer tag
*/
`timescale 1ns/1ps
`default_nettype none

module instructionValues (
  input  wire renamePkg::cdbT     cdb,      // Results broadcast this cycle
  input  wire renamePkg::dataT    operand,  // Register file value
  input  wire renamePkg::robValueT robValue, // Producer entry in the ROB
  input  wire renamePkg::robTagT  rob,      // Producer tag from status table
  input  wire logic               busy,     // Register has a pending producer
  output renamePkg::operandT      resolved
);

  logic cdbHit; // Producer is on the bus right now

  assign cdbHit = cdb.validBroadcast && (cdb.robEntry == rob);

  always_comb begin
    resolved.tag = rob; // Always passed on for the reservation station
    if (!busy) begin
      resolved.ready = 1'b1;
      resolved.value = operand;
    end else if (robValue.done) begin
      // Finished but not yet retired
      resolved.ready = 1'b1;
      resolved.value = robValue.value;
    end else if (cdbHit) begin
      resolved.ready = 1'b1; // Bypass from the bus
      resolved.value = cdb.result;
    end else begin
      // Still executing
      resolved.ready = 1'b0;
      resolved.value = '0;
    end
  end

  // A committing entry keeps its done bit until the edge,
  // so the ROB path covers the retirement cycle too

endmodule

`default_nettype wire

// ==== source/registerStatus.sv ====
/*
  Architectural register file with busy bit and producer tag per register
  Two combinational read ports, rename on allocate, write back on commit
*/
`timescale 1ns/1ps
`default_nettype none
`include "rename_defs.svh"

module registerStatus (
  input  wire logic              clk,
  input  wire logic              rstN,
  // Source lookups
  input  wire renamePkg::regIdxT src1,
  input  wire renamePkg::regIdxT src2,
  output renamePkg::dataT        value1,
  output renamePkg::dataT        value2,
  output logic                   busy1,
  output logic                   busy2,
  output renamePkg::robTagT      tag1,
  output renamePkg::robTagT      tag2,
  // Destination rename
  input  wire logic              allocate,
  input  wire renamePkg::regIdxT allocDest,
  input  wire renamePkg::robTagT allocTag,
  // Retirement from the ROB
  input  wire renamePkg::commitT commit
);

  renamePkg::dataT   regFile   [`REG_COUNT];
  logic              busyTable [`REG_COUNT];
  renamePkg::robTagT tagTable  [`REG_COUNT];

  logic commitFrees; // Committing entry is still the newest producer

  // Reads see state from before this cycle's updates
  assign value1 = regFile[src1];
  assign value2 = regFile[src2];
  assign busy1  = busyTable[src1];
  assign busy2  = busyTable[src2];
  assign tag1   = tagTable[src1];
  assign tag2   = tagTable[src2];

  assign commitFrees = commit.valid && busyTable[commit.dest] &&
                       (tagTable[commit.dest] == commit.robTag);

  // Architectural values, zero after reset
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < `REG_COUNT; i++) begin
        regFile[i] <= '0;
      end
    end else if (commit.valid) begin
      regFile[commit.dest] <= commit.value;
    end
  end

  // Busy and tag table
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < `REG_COUNT; i++) begin
        busyTable[i] <= 1'b0;
        tagTable[i]  <= '0;
      end
    end else begin
      if (commitFrees) begin
        busyTable[commit.dest] <= 1'b0;
      end
      // Later write wins when both target one register
      if (allocate) begin
        busyTable[allocDest] <= 1'b1;
        tagTable[allocDest]  <= allocTag;
      end
    end
  end

  // A commit whose tag was overwritten leaves the register busy
  // so readers keep waiting on the newer producer

endmodule

`default_nettype wire

// ==== source/renamePkg.sv ====
/*
  Shared types for the rename and dispatch stage
  Data words, register and tag indices, bus and record structs
*/
`default_nettype none
`include "rename_defs.svh"

package renamePkg;

  typedef logic [`DATA_WIDTH-1:0] dataT;  // One data word
  typedef logic [`REG_BITS-1:0]   regIdxT; // Architectural register index
  typedef logic [`ROB_BITS-1:0]   robTagT; // Reorder buffer entry index

  // Common data bus from the execution units
  typedef struct packed {
    logic   validBroadcast; // Result on the bus this cycle
    robTagT robEntry;       // Producing entry
    dataT   result;
  } cdbT;

  // Reorder buffer read port with done on top
  typedef struct packed {
    logic done;
    dataT value;
  } robValueT;

  typedef struct packed {
    logic   valid;
    regIdxT src1;
    regIdxT src2;
    regIdxT dest;
  } decodeT;

  // One source operand after rename
  typedef struct packed {
    logic   ready;
    dataT   value;  // Zero while waiting
    robTagT tag;    // Producer to wait on
  } operandT;

  // Record handed on to reservation station and ROB
  typedef struct packed {
    logic    valid;
    operandT op1;
    operandT op2;
    robTagT  robTag; // Newly allocated entry
    regIdxT  dest;
  } dispatchT;

  // In-order retirement into the register file
  typedef struct packed {
    logic   valid;
    regIdxT dest;
    dataT   value;
    robTagT robTag;
  } commitT;

endpackage

`default_nettype wire

// ==== source/renameStage.sv ====
/*
  Rename and dispatch stage
  Looks up both sources, resolves them against the ROB and the CDB,
  allocates a ROB entry for the destination and registers the dispatch record
*/
`timescale 1ns/1ps
`default_nettype none

module renameStage (
  input  wire logic              clk,
  input  wire logic              rstN,
  input  wire renamePkg::decodeT decode,        // Instruction to rename
  input  wire renamePkg::cdbT    cdb,           // Execution unit results
  output logic                   dispatchReady, // Low while the ROB is full
  output renamePkg::dispatchT    dispatch,
  output renamePkg::commitT      commit
);

  // Register status lookups
  renamePkg::dataT     value1;
  renamePkg::dataT     value2;
  logic                busy1;
  logic                busy2;
  renamePkg::robTagT   tag1;
  renamePkg::robTagT   tag2;

  // ROB side
  renamePkg::robValueT robValue1;
  renamePkg::robValueT robValue2;
  renamePkg::robTagT   tailTag;
  logic                full;
  renamePkg::commitT   robCommit;

  // Resolved operands
  renamePkg::operandT  op1;
  renamePkg::operandT  op2;

  logic accept; // Instruction taken this cycle

  // Dispatch register
  logic                dispatchValid;
  renamePkg::operandT  op1Q;
  renamePkg::operandT  op2Q;
  renamePkg::robTagT   robTagQ;
  renamePkg::regIdxT   destQ;

  assign dispatchReady = !full;
  assign accept        = decode.valid && !full; // Held instruction retries later

  registerStatus i_registerStatus (
    .clk       (clk),
    .rstN      (rstN),
    .src1      (decode.src1),
    .src2      (decode.src2),
    .value1    (value1),
    .value2    (value2),
    .busy1     (busy1),
    .busy2     (busy2),
    .tag1      (tag1),
    .tag2      (tag2),
    .allocate  (accept),
    .allocDest (decode.dest),
    .allocTag  (tailTag),     // Dest renamed to the new entry
    .commit    (robCommit)
  );

  robValueBuffer i_robValueBuffer (
    .clk        (clk),
    .rstN       (rstN),
    .allocate   (accept),
    .allocDest  (decode.dest),
    .tailTag    (tailTag),
    .full       (full),
    .cdb        (cdb),
    .readTag1   (tag1),       // Look up each source's producer
    .readTag2   (tag2),
    .readValue1 (robValue1),
    .readValue2 (robValue2),
    .commit     (robCommit)
  );

  // First source
  instructionValues i_instructionValues1 (
    .cdb      (cdb),
    .operand  (value1),
    .robValue (robValue1),
    .rob      (tag1),
    .busy     (busy1),
    .resolved (op1)
  );

  // Second source
  instructionValues i_instructionValues2 (
    .cdb      (cdb),
    .operand  (value2),
    .robValue (robValue2),
    .rob      (tag2),
    .busy     (busy2),
    .resolved (op2)
  );

  // One dispatch per accepted instruction, one cycle later
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) dispatchValid <= 1'b0;
    else       dispatchValid <= accept;
  end

  // Payload captured only on acceptance
  always_ff @(posedge clk) begin
    if (accept) begin
      op1Q    <= op1;
      op2Q    <= op2;
      robTagQ <= tailTag;
      destQ   <= decode.dest;
    end
  end

  assign dispatch = '{valid: dispatchValid, op1: op1Q, op2: op2Q,
                      robTag: robTagQ, dest: destQ};

  // Retirement goes to the register file and out of the stage
  assign commit = robCommit;

endmodule

`default_nettype wire

// ==== source/rename_defs.svh ====
/*
  Rename stage sizing
  Data width, architectural register count and reorder buffer depth
*/
`ifndef RENAME_DEFS_SVH
`define RENAME_DEFS_SVH

// Operand and result width
`define DATA_WIDTH 32

// Architectural register file
`define REG_COUNT 32
`define REG_BITS  5   // log2 of REG_COUNT

// Reorder buffer entries
`define ROB_DEPTH 8
`define ROB_BITS  3   // log2 of ROB_DEPTH

// Keep REG_BITS and ROB_BITS in step with the counts above
// Pointer wrap in the reorder buffer assumes a power of two depth

`endif

// ==== source/robValueBuffer.sv ====
/*
  Reorder buffer value store
  Circular buffer that allocates at the tail, takes results from the CDB
  and retires the head in program order, one entry per cycle
*/
`timescale 1ns/1ps
`default_nettype none
`include "rename_defs.svh"

module robValueBuffer (
  input  wire logic              clk,
  input  wire logic              rstN,
  // Allocation from the rename stage
  input  wire logic              allocate,
  input  wire renamePkg::regIdxT allocDest,
  output renamePkg::robTagT      tailTag,  // Entry the next allocate claims
  output logic                   full,
  // Completion
  input  wire renamePkg::cdbT    cdb,
  // Operand lookups
  input  wire renamePkg::robTagT readTag1,
  input  wire renamePkg::robTagT readTag2,
  output renamePkg::robValueT    readValue1,
  output renamePkg::robValueT    readValue2,
  // Registered retirement
  output renamePkg::commitT      commit
);

  renamePkg::robTagT      head;
  renamePkg::robTagT      tail;
  logic [`ROB_BITS:0]     count;        // One extra bit to hold ROB_DEPTH
  logic [`ROB_DEPTH-1:0]  doneBits;
  renamePkg::dataT        values [`ROB_DEPTH];
  renamePkg::regIdxT      dests  [`ROB_DEPTH];

  logic allocFire;
  logic commitFire;

  // Retirement register
  logic              commitValid;
  renamePkg::regIdxT commitDest;
  renamePkg::dataT   commitValue;
  renamePkg::robTagT commitTag;

  assign full       = (count == `ROB_DEPTH);
  assign tailTag    = tail;
  assign allocFire  = allocate && !full;             // Never overwrite a live entry
  assign commitFire = (count != '0) && doneBits[head]; // Oldest entry finished

  assign readValue1 = '{done: doneBits[readTag1], value: values[readTag1]};
  assign readValue2 = '{done: doneBits[readTag2], value: values[readTag2]};

  // Pointers and occupancy
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (allocFire) tail <= tail + 1'b1; // Wraps at ROB_DEPTH
      if (commitFire) head <= head + 1'b1;
      case ({allocFire, commitFire})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Done flags cleared on allocate and set by the CDB
  // A retired entry stays done until it is claimed again
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      doneBits <= '0;
    end else begin
      if (allocFire) doneBits[tail] <= 1'b0;
      if (cdb.validBroadcast) doneBits[cdb.robEntry] <= 1'b1;
    end
  end

  // Entry payload
  always_ff @(posedge clk) begin
    if (allocFire) dests[tail] <= allocDest;
    if (cdb.validBroadcast) values[cdb.robEntry] <= cdb.result;
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) commitValid <= 1'b0;
    else       commitValid <= commitFire;
  end

  always_ff @(posedge clk) begin
    if (commitFire) begin
      commitDest  <= dests[head];
      commitValue <= values[head];
      commitTag   <= head;
    end
  end

  assign commit = '{valid: commitValid, dest: commitDest,
                    value: commitValue, robTag: commitTag};

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+source
source/renamePkg.sv
source/instructionValues.sv
source/registerStatus.sv
source/robValueBuffer.sv
source/renameStage.sv
test/tbClock.sv
test/tbRenameStage.sv

// ==== test/tbClock.sv ====
/*
  Testbench clock source
  Free-running clock with an 8 ns period, low at time zero
*/
`timescale 1ns/1ps
`default_nettype none

module tbClock (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  always #4 clk = ~clk; // Half of the 8 ns period

endmodule

`default_nettype wire

// ==== test/tbRenameStage.sv ====
/*
  Testbench for the rename and dispatch stage
  Reference model of register status and reorder buffer, random sources and
  completions, assertion checks on every dispatch and commit
*/
`timescale 1ns/1ps
`default_nettype none
`include "rename_defs.svh"

module tbRenameStage;

  localparam int ClockPeriod    = 8;
  localparam int TestCount      = 6;
  localparam int WatchdogCycles = TestCount * 200 + 100; // 200 per test plus margin

  logic                rstN;
  logic                clk;
  renamePkg::decodeT   decode;
  renamePkg::cdbT      cdb;
  logic                dispatchReady;
  renamePkg::dispatchT dispatch;
  renamePkg::commitT   commit;

  // Model of the register side
  renamePkg::dataT     regVal  [`REG_COUNT];
  logic                busyReg [`REG_COUNT];
  renamePkg::robTagT   tagOf   [`REG_COUNT];
  // Model of the reorder buffer
  renamePkg::regIdxT   robDest [`ROB_DEPTH];
  renamePkg::dataT     robVal  [`ROB_DEPTH];
  logic                robDone [`ROB_DEPTH];
  renamePkg::robTagT   head;
  renamePkg::robTagT   tail;
  int                  count;     // Outstanding entries
  renamePkg::commitT   expCommit; // Commit now expected on the output

  renamePkg::decodeT   idle;
  renamePkg::cdbT      noBus;
  integer              seed;
  int                  passCount;
  int                  failCount;
  int                  failMark;  // failCount at the start of the test

  tbClock i_tbClock (.clk(clk));

  renameStage i_renameStage (
    .clk           (clk),
    .rstN          (rstN),
    .decode        (decode),
    .cdb           (cdb),
    .dispatchReady (dispatchReady),
    .dispatch      (dispatch),
    .commit        (commit)
  );

  // A stalled instruction never shows up as a dispatch
  stallBlocksDispatch: assert property (@(posedge clk) disable iff (!rstN)
    (decode.valid && !dispatchReady) |=> !dispatch.valid)
  else begin
    failCount++;
    $display("FAILED at %0t ns: dispatch.valid expected 0, got 1 after a stall", $time);
  end

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    assert (actual === expected) begin
      passCount++;
    end else begin
      failCount++;
      $display("FAILED at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  function automatic renamePkg::regIdxT randomReg();
    logic [31:0] r;
    r = $random(seed);
    return r[`REG_BITS-1:0];
  endfunction

  function automatic renamePkg::decodeT makeDecode(input renamePkg::regIdxT s1,
                                                   input renamePkg::regIdxT s2,
                                                   input renamePkg::regIdxT d);
    return '{valid: 1'b1, src1: s1, src2: s2, dest: d};
  endfunction

  function automatic renamePkg::cdbT makeBus(input renamePkg::robTagT t);
    logic [31:0] r;
    r = $random(seed);
    return '{validBroadcast: 1'b1, robEntry: t, result: r};
  endfunction

  // Not busy, then finished entry, then same-cycle bus, else wait on the tag
  function automatic renamePkg::operandT predictOperand(input renamePkg::regIdxT src,
                                                        input renamePkg::cdbT bus);
    renamePkg::operandT op;
    op.tag = tagOf[src];
    if (!busyReg[src]) begin
      op.ready = 1'b1;
      op.value = regVal[src];
    end else if (robDone[tagOf[src]]) begin
      op.ready = 1'b1;
      op.value = robVal[tagOf[src]];
    end else if (bus.validBroadcast && bus.robEntry == tagOf[src]) begin
      op.ready = 1'b1;
      op.value = bus.result;
    end else begin
      op.ready = 1'b0;
      op.value = '0;
    end
    return op;
  endfunction

  // Random completion among outstanding entries not yet done
  task automatic pickBroadcast(output renamePkg::cdbT c);
    renamePkg::robTagT pending [$];
    renamePkg::robTagT t;
    logic [31:0]       r;
    c = '0;
    t = head;
    for (int i = 0; i < count; i++) begin
      if (!robDone[t]) pending.push_back(t);
      t++;
    end
    if (pending.size() > 0) begin
      r = $random(seed);
      c = makeBus(pending[r % pending.size()]);
    end
  endtask

  // Drive one cycle, advance the model over the edge, then check the outputs
  task automatic runCycle(input renamePkg::decodeT d, input renamePkg::cdbT c,
                          output logic accepted);
    renamePkg::operandT exp1;
    renamePkg::operandT exp2;
    renamePkg::robTagT  expTag;
    renamePkg::commitT  nextCommit;
    logic               fire;
    decode = d;
    cdb    = c;
    checkValue("dispatchReady", count < `ROB_DEPTH, dispatchReady);
    accepted = d.valid && (count < `ROB_DEPTH);
    exp1   = predictOperand(d.src1, c); // Reads see the state before the edge
    exp2   = predictOperand(d.src2, c);
    expTag = tail;
    if (expCommit.valid) begin // Write back the retirement now on the bus
      regVal[expCommit.dest] = expCommit.value;
      if (busyReg[expCommit.dest] && tagOf[expCommit.dest] == expCommit.robTag)
        busyReg[expCommit.dest] = 1'b0;
    end
    fire       = (count != 0) && robDone[head];
    nextCommit = '{valid: fire, dest: robDest[head], value: robVal[head], robTag: head};
    if (accepted) begin // New producer wins over a commit to the same register
      busyReg[d.dest] = 1'b1;
      tagOf[d.dest]   = tail;
      robDest[tail]   = d.dest;
      robDone[tail]   = 1'b0;
      tail++;
      count++;
    end
    if (c.validBroadcast) begin
      robDone[c.robEntry] = 1'b1;
      robVal[c.robEntry]  = c.result;
    end
    if (fire) begin
      head++;
      count--;
    end
    expCommit = nextCommit;
    @(posedge clk);
    #1;
    checkValue("dispatch.valid", accepted, dispatch.valid);
    if (accepted) begin
      checkValue("dispatch.op1.ready", exp1.ready, dispatch.op1.ready);
      checkValue("dispatch.op1.value", exp1.value, dispatch.op1.value);
      checkValue("dispatch.op1.tag", exp1.tag, dispatch.op1.tag);
      checkValue("dispatch.op2.ready", exp2.ready, dispatch.op2.ready);
      checkValue("dispatch.op2.value", exp2.value, dispatch.op2.value);
      checkValue("dispatch.op2.tag", exp2.tag, dispatch.op2.tag);
      checkValue("dispatch.robTag", expTag, dispatch.robTag);
      checkValue("dispatch.dest", d.dest, dispatch.dest);
    end
    checkValue("commit.valid", expCommit.valid, commit.valid);
    if (expCommit.valid) begin
      checkValue("commit.dest", expCommit.dest, commit.dest);
      checkValue("commit.value", expCommit.value, commit.value);
      checkValue("commit.robTag", expCommit.robTag, commit.robTag);
    end
  endtask

  // Complete everything outstanding in random order and let it retire
  task automatic drain();
    renamePkg::cdbT c;
    logic           acc;
    while (count != 0 || expCommit.valid) begin
      pickBroadcast(c);
      runCycle(idle, c, acc);
    end
  endtask

  task automatic reportTest(input string name);
    if (failCount == failMark) $display("test %s: ok", name);
    else $display("test %s: %0d check(s) failed", name, failCount - failMark);
    failMark = failCount;
  endtask

  task automatic resetModel();
    for (int i = 0; i < `REG_COUNT; i++) begin
      regVal[i]  = '0;
      busyReg[i] = 1'b0;
      tagOf[i]   = '0;
    end
    for (int i = 0; i < `ROB_DEPTH; i++) begin
      robDest[i] = '0;
      robVal[i]  = '0;
      robDone[i] = 1'b0;
    end
    head      = '0;
    tail      = '0;
    count     = 0;
    expCommit = '0;
  endtask

  initial begin
    renamePkg::regIdxT a;
    renamePkg::regIdxT b;
    renamePkg::robTagT tagA;
    renamePkg::robTagT tagB;
    renamePkg::decodeT held;
    logic              acc;
    seed      = 88784;
    passCount = 0;
    failCount = 0;
    failMark  = 0;
    idle      = '0;
    noBus     = '0;
    decode    = '0;
    cdb       = '0;
    rstN      = 1'b0;
    resetModel();
    repeat (4) @(posedge clk);
    #1;
    rstN = 1'b1;
    checkValue("dispatch.valid", 1'b0, dispatch.valid);
    checkValue("commit.valid", 1'b0, commit.valid);

    // Zeros after reset and later the committed value
    a = randomReg();
    runCycle(makeDecode(randomReg(), randomReg(), a), noBus, acc);
    drain();
    runCycle(makeDecode(a, a, randomReg()), noBus, acc);
    drain();
    reportTest("independent sources");

    a = randomReg();
    runCycle(makeDecode(randomReg(), randomReg(), a), noBus, acc);
    runCycle(makeDecode(a, randomReg(), randomReg()), noBus, acc); // Producer still running
    drain();
    reportTest("pending dependency");

    a = randomReg();
    b = randomReg();
    if (b == a) b = a + 1'b1;
    runCycle(makeDecode(randomReg(), randomReg(), a), noBus, acc);
    tagB = tail;
    runCycle(makeDecode(randomReg(), randomReg(), b), noBus, acc);
    runCycle(idle, makeBus(tagB), acc);                    // Only the younger entry is done
    runCycle(makeDecode(b, b, randomReg()), noBus, acc);
    drain();
    reportTest("completed but uncommitted");

    a    = randomReg();
    tagA = tail;
    runCycle(makeDecode(randomReg(), randomReg(), a), noBus, acc);
    runCycle(makeDecode(a, randomReg(), randomReg()), makeBus(tagA), acc); // Bypass
    drain();
    reportTest("same-cycle bypass");

    repeat (6) runCycle(makeDecode(randomReg(), randomReg(), randomReg()), noBus, acc);
    drain();                                               // Completions out of order
    repeat (60) begin
      held = makeDecode(randomReg(), randomReg(), randomReg());
      held.valid = randomReg() > 5'd12;
      pickBroadcast(noBus);
      runCycle(held, noBus, acc);
    end
    noBus = '0;
    drain();
    reportTest("in-order retirement");

    repeat (`ROB_DEPTH) runCycle(makeDecode(randomReg(), randomReg(), randomReg()), noBus, acc);
    held = makeDecode(randomReg(), randomReg(), randomReg());
    tagA = head;
    repeat (3) runCycle(held, noBus, acc);                 // Held back while the buffer is full
    runCycle(held, makeBus(head), acc);
    acc = 1'b0;
    while (!acc) runCycle(held, noBus, acc);
    checkValue("dispatch.robTag", tagA, dispatch.robTag); // Reuses the freed head entry
    drain();
    reportTest("full-buffer stall");

    $display("checks passed: %0d, failed: %0d", passCount, failCount);
    if (failCount == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // Hang guard
  initial begin
    #(WatchdogCycles * ClockPeriod);
    $display("watchdog expired: tests did not finish within %0d cycles", WatchdogCycles);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire
